//--- sources.f
+incdir+.
encoder_pkg.sv
xgmii_pair.sv
block_encode.sv
tx_scrambler.sv
pcs_tx_top.sv
tb_clock.sv
tb_pcs_tx.sv

//--- run.sh
#!/bin/sh
# build and run the PCS transmit testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_pcs_tx -f sources.f -o tb_pcs_tx
./obj_dir/tb_pcs_tx | tee sim.log
grep -qF "All checks passed" sim.log
echo "simulation passed"

//--- tb_pcs_tx.sv
`include "pcs_macros.svh"

module tb_pcs_tx import encoder_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int PRE_INIT  = 9;
    localparam int NUM_WORDS = 4000;
    localparam int FLUSH     = 8;
    // reset, idle, stimulus and flush cycles plus slack, 4 ns each
    localparam int WATCHDOG_NS = (2 + PRE_INIT + NUM_WORDS + FLUSH + 40) * 4;
    localparam logic [7:0] BT_TERM [8] = '{`BT_T0, `BT_T1, `BT_T2, `BT_T3,
                                           `BT_T4, `BT_T5, `BT_T6, `BT_T7};

    logic        i_txc;
    logic        i_reset;
    logic        i_init_done;
    xgmii_data_t i_txd;
    xgmii_ctl_t  i_txctl;
    logic [65:0] o_txd;
    logic        o_tx_valid;

    logic [31:0] lfsr;
    // past[n] is the scrambled bit n positions back
    logic [58:1] scr_past;
    // {ctl, byte} per lane, waiting to be driven
    logic [8:0]  lanes[$];
    int          pushed;
    int          cyc;
    int          checked;
    logic        phase_hi;
    xgmii_data_t low_txd;
    xgmii_ctl_t  low_ctl;
    logic [65:0] exp_txd[$];
    int          exp_cyc[$];
    string       exp_name[$];

    tb_clock u_tb_clock (.o_txc(i_txc), .o_reset(i_reset));

    pcs_tx_top u_pcs_tx_top (.*);

    task automatic report_problem(input string msg);
        $display("%s", msg);
        $display("Checks failed");
        $fatal(1);
    endtask

    // fibonacci lfsr x^32 + x^22 + x^2 + x + 1
    function automatic logic next_bit();
        logic fb;
        fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic int rand_bits(input int n);
        int v;
        v = 0;
        for (int k = 0; k < n; k++) begin
            v = (v << 1) | int'(next_bit());
        end
        return v;
    endfunction

    task automatic push_lane(input logic ctl, input logic [7:0] val);
        lanes.push_back({ctl, val});
        pushed++;
    endtask

    task automatic pad_idle(input int align);
        while (pushed % align != 0) begin
            push_lane(1'b1, `RS_IDLE);
        end
    endtask

    // idle run, frame, one or two ordered sets, or a stray control byte
    task automatic add_segment();
        int kind;
        int len;
        kind = rand_bits(3);
        if (kind < 2) begin
            len = 1 + rand_bits(4);
            repeat (len) push_lane(1'b1, `RS_IDLE);
            pad_idle(4);
        end else if (kind < 5) begin
            // start on lane 0 or 4, random length moves /T/ over all lanes
            pad_idle(4);
            push_lane(1'b1, `RS_START);
            len = 7 + rand_bits(6);
            repeat (len) push_lane(1'b0, 8'(rand_bits(8)));
            push_lane(1'b1, `RS_TERM);
            pad_idle(8);
        end else if (kind < 7) begin
            // kind 6 puts two sets in one block
            pad_idle(kind == 6 ? 8 : 4);
            repeat (kind - 4) begin
                push_lane(1'b1, next_bit() ? `RS_OSIG : `RS_OSEQ);
                repeat (3) push_lane(1'b0, 8'(rand_bits(8)));
            end
        end else begin
            push_lane(1'b1, 8'(rand_bits(8)));
            pad_idle(4);
        end
    endtask

    function automatic logic is_oset(input logic [7:0] ch);
        return (ch == `RS_OSEQ) || (ch == `RS_OSIG);
    endfunction

    function automatic ocode_t ocode_of(input logic [7:0] ch);
        return (ch == `RS_OSIG) ? `OC_SIG : `OC_SEQ;
    endfunction

    // control block payload by lane pattern, first match wins
    function automatic string encode_block(input blk_data_t d, input blk_ctl_t c,
                                           output blk_data_t p);
        logic [7:0] ch[8];
        logic       lo_idle;
        logic       hi_idle;
        logic       lo_dat;
        logic       hi_dat;
        int         first;
        string      kind;
        first = 8;
        for (int n = 7; n >= 0; n--) begin
            // data lanes read as /E/
            ch[n] = c[n] ? d[8*n +: 8] : `RS_ERROR;
            if (c[n]) begin
                first = n;
            end
        end
        lo_idle = (c[3:0] == 4'hf) && (d[31:0] == {4{`RS_IDLE}});
        hi_idle = (c[7:4] == 4'hf) && (d[63:32] == {4{`RS_IDLE}});
        lo_dat  = (c[3:1] == 3'b000);
        hi_dat  = (c[7:5] == 3'b000);
        p = '0;
        if (c == 8'h00) begin
            p = d;
            kind = "data";
        end else if (lo_idle && hi_idle) begin
            p = {{8{`CC_IDLE}}, `BT_IDLE};
            kind = "idle";
        end else if (lo_idle && is_oset(ch[4]) && hi_dat) begin
            p = {d[63:40], ocode_of(ch[4]), {4{`CC_IDLE}}, `BT_O4};
            kind = "o4";
        end else if (lo_idle && ch[4] == `RS_START && hi_dat) begin
            p = {d[63:40], 4'h0, {4{`CC_IDLE}}, `BT_S4};
            kind = "s4";
        end else if (is_oset(ch[0]) && lo_dat && ch[4] == `RS_START && hi_dat) begin
            p = {d[63:40], 4'h0, ocode_of(ch[0]), d[31:8], `BT_O0S4};
            kind = "o0s4";
        end else if (is_oset(ch[0]) && lo_dat && is_oset(ch[4]) && hi_dat) begin
            p = {d[63:40], ocode_of(ch[4]), ocode_of(ch[0]), d[31:8], `BT_O0O4};
            kind = "o0o4";
        end else if (ch[0] == `RS_START && c[7:1] == 7'h00) begin
            p = {d[63:8], `BT_S0};
            kind = "s0";
        end else if (is_oset(ch[0]) && lo_dat && hi_idle) begin
            p = {{4{`CC_IDLE}}, ocode_of(ch[0]), d[31:8], `BT_O0};
            kind = "o0";
        end else if (first < 8 && ch[first] == `RS_TERM && c == (8'hff << first)) begin
            // data bytes right after the type, idle codes past /T/ are zero
            p[7:0] = BT_TERM[first];
            for (int n = 0; n < first; n++) begin
                p[8 + 8*n +: 8] = d[8*n +: 8];
            end
            kind = $sformatf("t%0d", first);
        end else begin
            p = {{8{`CC_ERROR}}, `BT_IDLE};
            kind = "error";
        end
        return kind;
    endfunction

    // each bit xor scrambled bits 39 and 58 back, bit 0 first
    function automatic blk_data_t scramble(input blk_data_t p);
        blk_data_t s;
        for (int i = 0; i < 64; i++) begin
            s[i] = p[i] ^ scr_past[39] ^ scr_past[58];
            scr_past = {scr_past[57:1], s[i]};
        end
        return s;
    endfunction

    // pair words, then expect the block three cycles after the high word
    task automatic model_word(input xgmii_data_t w, input xgmii_ctl_t f);
        blk_data_t p;
        sync_t     hdr;
        string     kind;
        if (!phase_hi) begin
            low_txd = w;
            low_ctl = f;
        end else begin
            kind = encode_block({w, low_txd}, {f, low_ctl}, p);
            hdr = (kind == "data") ? `SYNC_DATA : `SYNC_CTL;
            exp_txd.push_back({scramble(p), hdr});
            exp_cyc.push_back(cyc + 3);
            exp_name.push_back($sformatf("%s block at cycle %0d", kind, cyc + 3));
        end
        phase_hi = !phase_hi;
    endtask

    task automatic check_outputs();
        logic [65:0] exp;
        string       name;
        assert (!$isunknown(o_tx_valid)) else report_problem("o_tx_valid is unknown");
        if (o_tx_valid) begin
            assert (exp_cyc.size() > 0 && exp_cyc[0] == cyc) else
                report_problem($sformatf("unexpected o_tx_valid at cycle %0d", cyc));
            exp = exp_txd.pop_front();
            name = exp_name.pop_front();
            void'(exp_cyc.pop_front());
            checked++;
            assert (o_txd === exp) else
                report_problem($sformatf("[FAIL] %s expected %h actual %h", name, exp, o_txd));
        end else begin
            assert (exp_cyc.size() == 0 || exp_cyc[0] != cyc) else
                report_problem($sformatf("o_tx_valid missing at cycle %0d", cyc));
        end
    endtask

    // outputs checked, then new inputs, both on the falling edge
    task automatic run_cycle(input logic init, input xgmii_data_t w, input xgmii_ctl_t f);
        check_outputs();
        i_init_done = init;
        i_txd = w;
        i_txctl = f;
        if (init) begin
            model_word(w, f);
        end
        cyc++;
        @(negedge i_txc);
    endtask

    task automatic next_word(output xgmii_data_t w, output xgmii_ctl_t f);
        logic [8:0] l;
        while (lanes.size() < 4) begin
            add_segment();
        end
        for (int k = 0; k < 4; k++) begin
            l = lanes.pop_front();
            w[8*k +: 8] = l[7:0];
            f[k] = l[8];
        end
    endtask

    initial begin
        #(WATCHDOG_NS);
        report_problem("watchdog expired before the stimulus finished");
    end

    initial begin
        xgmii_data_t w;
        xgmii_ctl_t  f;
        i_init_done = 1'b0;
        i_txd = {4{`RS_IDLE}};
        i_txctl = 4'hf;
        lfsr = 32'h0df9e5d7;
        scr_past = `SCR_SEED;
        pushed = 0;
        cyc = 0;
        checked = 0;
        phase_hi = 1'b0;
        @(negedge i_txc);
        while (i_reset !== 1'b0) begin
            @(negedge i_txc);
        end
        // init low, no block may leave
        repeat (PRE_INIT) run_cycle(1'b0, {4{`RS_IDLE}}, 4'hf);
        repeat (NUM_WORDS) begin
            next_word(w, f);
            run_cycle(1'b1, w, f);
        end
        // dropping init lets the last blocks drain
        repeat (FLUSH) run_cycle(1'b0, {4{`RS_IDLE}}, 4'hf);
        check_outputs();
        if (exp_txd.size() == 0 && checked == NUM_WORDS / 2) begin
            $display("All checks passed");
            $finish;
        end else begin
            report_problem($sformatf("only %0d of %0d blocks came out", checked, NUM_WORDS / 2));
        end
    end

endmodule

//--- tb_clock.sv
module tb_clock (
    output logic o_txc,
    output logic o_reset
);
    timeunit 1ns;
    timeprecision 1ps;

    // 4 ns period
    initial begin
        o_txc = 1'b0;
        forever #2 o_txc = ~o_txc;
    end

    // reset held over the first two rising edges
    initial begin
        o_reset = 1'b1;
        repeat (2) @(posedge o_txc);
        o_reset <= 1'b0;
    end

endmodule

//--- pcs_tx_top.sv
module pcs_tx_top import encoder_pkg::*; (
    input  logic        i_txc,
    input  logic        i_reset,
    input  logic        i_init_done,
    input  xgmii_data_t i_txd,
    input  xgmii_ctl_t  i_txctl,
    output logic [65:0] o_txd,
    output logic        o_tx_valid
);

    // pairer to encoder
    blk_data_t blk_data;
    blk_ctl_t  blk_ctl;
    logic      blk_valid;

    // encoder to scrambler
    sync_t     enc_sync;
    blk_data_t enc_payload;
    logic      enc_valid;

    // two words in, one block strobe every second cycle
    xgmii_pair u_xgmii_pair (
        .i_txc       (i_txc),
        .i_reset     (i_reset),
        .i_init_done (i_init_done),
        .i_txd       (i_txd),
        .i_txctl     (i_txctl),
        .o_blk_data  (blk_data),
        .o_blk_ctl   (blk_ctl),
        .o_blk_valid (blk_valid)
    );

    block_encode u_block_encode (
        .i_txc       (i_txc),
        .i_reset     (i_reset),
        .i_blk_data  (blk_data),
        .i_blk_ctl   (blk_ctl),
        .i_blk_valid (blk_valid),
        .o_sync      (enc_sync),
        .o_payload   (enc_payload),
        .o_valid     (enc_valid)
    );

    // block leaves three cycles after its high word
    tx_scrambler u_tx_scrambler (
        .i_txc      (i_txc),
        .i_reset    (i_reset),
        .i_sync     (enc_sync),
        .i_payload  (enc_payload),
        .i_valid    (enc_valid),
        .o_txd      (o_txd),
        .o_tx_valid (o_tx_valid)
    );

endmodule

//--- tx_scrambler.sv
`include "pcs_macros.svh"

module tx_scrambler import encoder_pkg::*; (
    input  logic        i_txc,
    input  logic        i_reset,
    input  sync_t       i_sync,
    input  blk_data_t   i_payload,
    input  logic        i_valid,
    output logic [65:0] o_txd,
    output logic        o_tx_valid
);

    // last 58 scrambled bits, bit 0 is the newest
    logic [57:0] scr_state;
    logic [57:0] scr_next;
    blk_data_t   scr_payload;

    // x^58 + x^39 + 1, payload bit 0 goes first
    always_comb begin
        logic [57:0] hist;
        hist = scr_state;
        for (int i = 0; i < 64; i++) begin
            scr_payload[i] = i_payload[i] ^ hist[38] ^ hist[57];
            hist           = {hist[56:0], scr_payload[i]};
        end
        scr_next = hist;
    end

    // history moves only on a strobe
    always_ff @(posedge i_txc) begin
        if (i_reset) begin
            scr_state  <= `SCR_SEED;
            o_tx_valid <= 1'b0;
        end else begin
            o_tx_valid <= i_valid;
            if (i_valid) begin
                scr_state <= scr_next;
            end
        end
    end

    // header bypasses the scrambler, sits in bits 1:0
    always_ff @(posedge i_txc) begin
        if (i_valid) begin
            o_txd <= {scr_payload, i_sync};
        end
    end

endmodule

//--- block_encode.sv
`include "pcs_macros.svh"

module block_encode import encoder_pkg::*; (
    input  logic      i_txc,
    input  logic      i_reset,
    input  blk_data_t i_blk_data,
    input  blk_ctl_t  i_blk_ctl,
    input  logic      i_blk_valid,
    output sync_t     o_sync,
    output blk_data_t o_payload,
    output logic      o_valid
);

    // type byte per terminate lane, index is the lane of /T/
    localparam logic [7:0][7:0] BT_TERM = {
        `BT_T7, `BT_T6, `BT_T5, `BT_T4,
        `BT_T3, `BT_T2, `BT_T1, `BT_T0
    };

    // ordered-set character to its O code
    function automatic ocode_t to_ocode(input logic [7:0] rs_char);
        return (rs_char == `RS_OSEQ) ? `OC_SEQ : `OC_SIG;
    endfunction

    logic [7:0][7:0] lane_chr;
    logic [7:0]      is_idle;
    logic [7:0]      is_os;
    logic            lo_idle;
    logic            hi_idle;
    logic            lo_data;
    logic            hi_data;
    logic [23:0]     d_lo;
    logic [23:0]     d_hi;
    logic            term_hit;
    blk_data_t       term_payload;
    sync_t           next_sync;
    blk_data_t       next_payload;

    // per-lane control character
    // data lanes read as /E/ so they never match a control pattern
    always_comb begin
        for (int k = 0; k < 8; k++) begin
            lane_chr[k] = i_blk_ctl[k] ? i_blk_data[8*k +: 8] : `RS_ERROR;
            is_idle[k]  = (lane_chr[k] == `RS_IDLE);
            is_os[k]    = (lane_chr[k] == `RS_OSEQ) || (lane_chr[k] == `RS_OSIG);
        end
    end

    // lane groups used by the block formats
    assign lo_idle = &is_idle[3:0];
    assign hi_idle = &is_idle[7:4];
    // lanes 1-3 and 5-7 carry plain data
    assign lo_data = (i_blk_ctl[3:1] == 3'b000);
    assign hi_data = (i_blk_ctl[7:5] == 3'b000);
    assign d_lo    = i_blk_data[31:8];
    assign d_hi    = i_blk_data[63:40];

    // terminate search
    // flags must be clear below /T/ and set from /T/ upwards
    // loop runs high to low so the lowest lane wins
    always_comb begin
        term_hit     = 1'b0;
        term_payload = '0;
        for (int k = 7; k >= 0; k--) begin
            if (i_blk_ctl == (8'hff << k) && lane_chr[k] == `RS_TERM) begin
                term_hit         = 1'b1;
                term_payload     = '0;
                term_payload[7:0] = BT_TERM[k];
                // data bytes packed right after the type byte
                for (int j = 0; j < 7; j++) begin
                    if (j < k) begin
                        term_payload[8 + 8*j +: 8] = i_blk_data[8*j +: 8];
                    end
                end
                // lanes past /T/ sit at bit 8+7*lane, reserved bits stay zero
                for (int j = 1; j < 8; j++) begin
                    if (j > k) begin
                        term_payload[8 + 7*j +: 7] = `CC_IDLE;
                    end
                end
            end
        end
    end

    // block format select, first match wins
    always_comb begin
        next_sync    = `SYNC_CTL;
        // unknown pattern -> error block
        // eight /E/ codes fill the 56 bits after the type
        next_payload = {{8{`CC_ERROR}}, `BT_IDLE};
        if (i_blk_ctl == '0) begin
            next_sync    = `SYNC_DATA;
            next_payload = i_blk_data;
        end else if (lo_idle && hi_idle) begin
            next_payload = {{8{`CC_IDLE}}, `BT_IDLE};
        end else if (lo_idle && is_os[4] && hi_data) begin
            next_payload = {d_hi, to_ocode(lane_chr[4]), {4{`CC_IDLE}}, `BT_O4};
        end else if (lo_idle && lane_chr[4] == `RS_START && hi_data) begin
            // start lane carries no code, nibble left zero
            next_payload = {d_hi, 4'h0, {4{`CC_IDLE}}, `BT_S4};
        end else if (is_os[0] && lo_data && lane_chr[4] == `RS_START && hi_data) begin
            next_payload = {d_hi, 4'h0, to_ocode(lane_chr[0]), d_lo, `BT_O0S4};
        end else if (is_os[0] && lo_data && is_os[4] && hi_data) begin
            next_payload = {d_hi, to_ocode(lane_chr[4]), to_ocode(lane_chr[0]), d_lo,
                            `BT_O0O4};
        end else if (lane_chr[0] == `RS_START && i_blk_ctl[7:1] == 7'h00) begin
            next_payload = {i_blk_data[63:8], `BT_S0};
        end else if (is_os[0] && lo_data && hi_idle) begin
            next_payload = {{4{`CC_IDLE}}, to_ocode(lane_chr[0]), d_lo, `BT_O0};
        end else if (term_hit) begin
            next_payload = term_payload;
        end
    end

    // one cycle from strobe in to strobe out
    always_ff @(posedge i_txc) begin
        if (i_reset) begin
            o_valid <= 1'b0;
        end else begin
            o_valid <= i_blk_valid;
        end
    end

    always_ff @(posedge i_txc) begin
        if (i_blk_valid) begin
            o_sync    <= next_sync;
            o_payload <= next_payload;
        end
    end

endmodule

//--- xgmii_pair.sv
module xgmii_pair import encoder_pkg::*; (
    input  logic        i_txc,
    input  logic        i_reset,
    input  logic        i_init_done,
    input  xgmii_data_t i_txd,
    input  xgmii_ctl_t  i_txctl,
    output blk_data_t   o_blk_data,
    output blk_ctl_t    o_blk_ctl,
    output logic        o_blk_valid
);

    phase_t      phase;
    // first word of the block in progress
    xgmii_data_t low_data;
    xgmii_ctl_t  low_ctl;

    // phase toggles only once init is done
    // strobe follows the cycle that carried the high word
    always_ff @(posedge i_txc) begin
        if (i_reset || !i_init_done) begin
            phase       <= PH_LOW;
            o_blk_valid <= 1'b0;
        end else begin
            o_blk_valid <= (phase == PH_HIGH);
            phase       <= (phase == PH_LOW) ? PH_HIGH : PH_LOW;
        end
    end

    // low word parked, high word joins it above
    always_ff @(posedge i_txc) begin
        if (phase == PH_LOW) begin
            low_data <= i_txd;
            low_ctl  <= i_txctl;
        end else begin
            // first byte of the pair stays in bits 7:0
            o_blk_data <= {i_txd, low_data};
            o_blk_ctl  <= {i_txctl, low_ctl};
        end
    end

endmodule

//--- encoder_pkg.sv
package encoder_pkg;

    // mac side, one 32-bit word per i_txc cycle
    // lane 0 is the first byte on the wire, bits 7:0
    typedef logic [31:0] xgmii_data_t;

    // one control flag per byte lane of a word
    // set means the lane holds a control character
    typedef logic [3:0] xgmii_ctl_t;

    // two words paired into one 64-bit block
    // low word in bits 31:0, lane 0 still in bits 7:0
    typedef logic [63:0] blk_data_t;

    // control flags for all eight lanes of a block
    typedef logic [7:0] blk_ctl_t;

    // 64b/66b sync header
    // 01 for data blocks, 10 for control blocks
    typedef logic [1:0] sync_t;

    // 4-bit O code of an ordered set
    // sequence or signal ordered set
    typedef logic [3:0] ocode_t;

    // which half of a block the current word fills
    // PH_LOW holds the word, PH_HIGH completes the block
    typedef enum logic {
        PH_LOW  = 1'b0,
        PH_HIGH = 1'b1
    } phase_t;

endpackage

//--- pcs_macros.svh
`ifndef PCS_MACROS_SVH
`define PCS_MACROS_SVH

// sync headers
`define SYNC_DATA 2'b01
`define SYNC_CTL  2'b10

// xgmii control characters
`define RS_IDLE  8'h07
`define RS_START 8'hfb
`define RS_TERM  8'hfd
`define RS_ERROR 8'hfe
`define RS_OSEQ  8'h9c
`define RS_OSIG  8'h5c

// 7-bit control codes inside a control block
`define CC_IDLE  7'h00
`define CC_ERROR 7'h1e

// O codes for sequence and signal ordered sets
`define OC_SEQ 4'h0
`define OC_SIG 4'hf

// block type field, low byte of the payload
`define BT_IDLE 8'h1e
`define BT_O4   8'h2d
`define BT_S4   8'h33
`define BT_O0S4 8'h66
`define BT_O0O4 8'h55
`define BT_S0   8'h78
`define BT_O0   8'h4b
`define BT_T0   8'h87
`define BT_T1   8'h99
`define BT_T2   8'haa
`define BT_T3   8'hb4
`define BT_T4   8'hcc
`define BT_T5   8'hd2
`define BT_T6   8'he1
`define BT_T7   8'hff

// scrambler history after reset, all ones
`define SCR_SEED {58{1'b1}}

`endif
